// ==== verilog/csc_consts.svh ====
`ifndef CSC_CONSTS_SVH
`define CSC_CONSTS_SVH

// Datapath widths.
`define CSC_COMP_W 8
`define CSC_MAG_W  16
`define CSC_FRAC_W 12
`define CSC_TERM_W (`CSC_COMP_W + `CSC_MAG_W + 1) // Sign plus full product magnitude.

// Pipeline latencies in clock cycles.
`define CSC_MUL_LAT 2
`define CSC_ADD_LAT 4
`define CSC_LAT     (`CSC_MUL_LAT + `CSC_ADD_LAT)

`define CSC_FIFO_DEPTH 16

// APB byte addresses. Register n of the coefficient block sits at base + 4 * n,
// where n is channel * 4 + term and term 3 is the offset.
`define CSC_ADDR_COEF_BASE 8'h00
`define CSC_ADDR_LEVEL     8'h30

`endif

// ==== verilog/csc_pixel_pkg.sv ====
`default_nettype none

`include "csc_consts.svh"

package csc_pixel_pkg;

  // One unsigned colour component.
  typedef logic [`CSC_COMP_W-1:0] comp_t;

  // Three components, component 2 in the high byte.
  typedef logic [2:0][`CSC_COMP_W-1:0] pixel_t;

  // Sign-magnitude term. The top bit is the sign and the rest is the magnitude
  // with CSC_FRAC_W fraction bits.
  typedef logic [`CSC_TERM_W-1:0] term_t;

endpackage

`default_nettype wire

// ==== verilog/csc_coef_pkg.sv ====
`default_nettype none

`include "csc_consts.svh"

package csc_coef_pkg;

  // Sign-magnitude coefficient. Bit CSC_MAG_W is the sign and the magnitude
  // below it has CSC_FRAC_W fraction bits, so 1.0 is 16'h1000.
  typedef logic [`CSC_MAG_W:0] coef_t;

  // Register index, channel in the upper two bits and term in the lower two.
  typedef logic [3:0] coef_idx_t;

endpackage

`default_nettype wire

// ==== verilog/csc_coef_regs.sv ====
`default_nettype none

`include "csc_consts.svh"

module csc_coef_regs
  import csc_pixel_pkg::*;
  import csc_coef_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [7:0]  paddr,
  input  wire  [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  wire  [4:0]  level,
  output coef_t       coef_c0_0,
  output coef_t       coef_c0_1,
  output coef_t       coef_c0_2,
  output coef_t       coef_c1_0,
  output coef_t       coef_c1_1,
  output coef_t       coef_c1_2,
  output coef_t       coef_c2_0,
  output coef_t       coef_c2_1,
  output coef_t       coef_c2_2,
  output term_t       offset_c0,
  output term_t       offset_c1,
  output term_t       offset_c2
);

  coef_t      coef_q [3][3];
  term_t      offset_q [3];
  logic [7:0] rel_addr;
  coef_idx_t  idx;
  logic       coef_hit;
  logic       level_hit;
  logic       access;

  assign rel_addr  = paddr - `CSC_ADDR_COEF_BASE;
  assign idx       = rel_addr[5:2];
  assign coef_hit  = (rel_addr[7:6] == 2'b00) && (rel_addr[1:0] == 2'b00) && (idx[3:2] != 2'd3);
  assign level_hit = (paddr == `CSC_ADDR_LEVEL);
  assign access    = psel && penable;

  assign pready  = 1'b1; // No wait states.
  assign pslverr = access && (!(coef_hit || level_hit) || (pwrite && level_hit));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int c = 0; c < 3; c++) begin
        offset_q[c] <= '0;
        for (int t = 0; t < 3; t++) begin
          coef_q[c][t] <= '0;
        end
      end
    end else if (access && pwrite && coef_hit) begin
      if (idx[1:0] == 2'd3) begin
        offset_q[idx[3:2]] <= pwdata[`CSC_TERM_W-1:0];
      end else begin
        coef_q[idx[3:2]][idx[1:0]] <= pwdata[`CSC_MAG_W:0];
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (coef_hit) begin
      if (idx[1:0] == 2'd3) prdata = 32'(offset_q[idx[3:2]]);
      else prdata = 32'(coef_q[idx[3:2]][idx[1:0]]);
    end else if (level_hit) begin
      prdata = 32'(level);
    end
  end

  assign coef_c0_0 = coef_q[0][0];
  assign coef_c0_1 = coef_q[0][1];
  assign coef_c0_2 = coef_q[0][2];
  assign coef_c1_0 = coef_q[1][0];
  assign coef_c1_1 = coef_q[1][1];
  assign coef_c1_2 = coef_q[1][2];
  assign coef_c2_0 = coef_q[2][0];
  assign coef_c2_1 = coef_q[2][1];
  assign coef_c2_2 = coef_q[2][2];
  assign offset_c0 = offset_q[0];
  assign offset_c1 = offset_q[1];
  assign offset_c2 = offset_q[2];

endmodule

`default_nettype wire

// ==== verilog/csc_mul.sv ====
`default_nettype none

`include "csc_consts.svh"

module csc_mul
  import csc_pixel_pkg::*;
  import csc_coef_pkg::*;
(
  input  wire   clk,
  input  wire   comp_t comp,
  input  wire   coef_t coef,
  output term_t term
);

  logic [`CSC_TERM_W-2:0] prod_q;
  logic                   sign_q;

  // The component is unsigned, so the product sign is the coefficient sign.
  always_ff @(posedge clk) begin
    prod_q <= comp * coef[`CSC_MAG_W-1:0];
    sign_q <= coef[`CSC_MAG_W];
  end

  // A zero product is always positive so the adder never sees a negative zero.
  always_ff @(posedge clk) begin
    term <= {sign_q && (prod_q != '0), prod_q};
  end

endmodule

`default_nettype wire

// ==== verilog/csc_add.sv ====
`default_nettype none

`include "csc_consts.svh"

module csc_add
  import csc_pixel_pkg::*;
#(
  parameter int DELAY_W = 1
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire  term_t        term_0,
  input  wire  term_t        term_1,
  input  wire  term_t        term_2,
  input  wire  term_t        term_3,
  input  wire  [DELAY_W-1:0] ddata_in,
  output logic [DELAY_W-1:0] ddata_out,
  output comp_t              result
);

  // Two guard bits so the sum of four full-scale terms cannot wrap.
  localparam int SUM_W = `CSC_TERM_W + 2;
  localparam int HI    = `CSC_FRAC_W + `CSC_COMP_W;

  logic signed [SUM_W-1:0] s1_term [4];
  logic signed [SUM_W-1:0] s2_sum_a;
  logic signed [SUM_W-1:0] s2_sum_b;
  logic signed [SUM_W-1:0] s3_total;
  logic [DELAY_W-1:0]      s1_ddata;
  logic [DELAY_W-1:0]      s2_ddata;
  logic [DELAY_W-1:0]      s3_ddata;

  function automatic logic signed [SUM_W-1:0] to_twos(input term_t t);
    logic signed [SUM_W-1:0] mag;
    mag = {3'b000, t[`CSC_TERM_W-2:0]};
    return t[`CSC_TERM_W-1] ? -mag : mag;
  endfunction

  always_ff @(posedge clk) begin
    s1_term[0] <= to_twos(term_0);
    s1_term[1] <= to_twos(term_1);
    s1_term[2] <= to_twos(term_2);
    s1_term[3] <= to_twos(term_3);
    s2_sum_a   <= s1_term[0] + s1_term[1];
    s2_sum_b   <= s1_term[2] + s1_term[3];
    s3_total   <= s2_sum_a + s2_sum_b;
    if (s3_total[SUM_W-1]) result <= '0;
    else if (s3_total[SUM_W-2:HI] != '0) result <= '1; // Saturate above 255.
    else result <= s3_total[HI-1:`CSC_FRAC_W];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_ddata  <= '0;
      s2_ddata  <= '0;
      s3_ddata  <= '0;
      ddata_out <= '0;
    end else begin
      s1_ddata  <= ddata_in;
      s2_ddata  <= s1_ddata;
      s3_ddata  <= s2_ddata;
      ddata_out <= s3_ddata;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/csc_channel.sv ====
`default_nettype none

`include "csc_consts.svh"

module csc_channel
  import csc_pixel_pkg::*;
  import csc_coef_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire pixel_t pixel,
  input  wire coef_t  coef_0,
  input  wire coef_t  coef_1,
  input  wire coef_t  coef_2,
  input  wire term_t  offset,
  input  wire [1:0]   tag_in, // Valid and ready; the tag is their AND.
  output logic        tag_out,
  output comp_t       result
);

  logic [`CSC_MUL_LAT-1:0] tag_dly;
  term_t                   offset_dly [`CSC_MUL_LAT];
  term_t                   term_0;
  term_t                   term_1;
  term_t                   term_2;

  // Offset and tag wait out the multiplier stages to meet the products.
  always_ff @(posedge clk) begin
    if (!rst_n) tag_dly <= '0;
    else tag_dly <= {tag_dly[`CSC_MUL_LAT-2:0], tag_in[1] & tag_in[0]};
  end

  always_ff @(posedge clk) begin
    offset_dly[0] <= offset;
    for (int i = 1; i < `CSC_MUL_LAT; i++) begin
      offset_dly[i] <= offset_dly[i-1];
    end
  end

  csc_mul u_mul_0 (.clk(clk), .comp(pixel[0]), .coef(coef_0), .term(term_0));
  csc_mul u_mul_1 (.clk(clk), .comp(pixel[1]), .coef(coef_1), .term(term_1));
  csc_mul u_mul_2 (.clk(clk), .comp(pixel[2]), .coef(coef_2), .term(term_2));

  csc_add #(.DELAY_W(1)) u_add (
    .clk(clk), .rst_n(rst_n),
    .term_0(term_0), .term_1(term_1), .term_2(term_2),
    .term_3(offset_dly[`CSC_MUL_LAT-1]),
    .ddata_in(tag_dly[`CSC_MUL_LAT-1]), .ddata_out(tag_out),
    .result(result)
  );

endmodule

`default_nettype wire

// ==== verilog/csc_pixel_fifo.sv ====
`default_nettype none

`include "csc_consts.svh"

module csc_pixel_fifo
  import csc_pixel_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         wr_en,
  input  wire pixel_t wr_pixel,
  output logic        in_ready,
  output logic        out_valid,
  output pixel_t      out_pixel,
  input  wire         out_ready,
  output logic [4:0]  level
);

  localparam int PTR_W = $clog2(`CSC_FIFO_DEPTH);

  pixel_t           mem [`CSC_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [4:0]       count;
  logic             push;
  logic             pop;

  assign push = wr_en && (count != `CSC_FIFO_DEPTH);
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wr_pixel;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // Leave room for every pixel that can still be in the pipeline.
  assign in_ready  = (count <= `CSC_FIFO_DEPTH - `CSC_LAT - 1);
  assign out_valid = (count != '0);
  assign out_pixel = mem[rd_ptr]; // Head word falls through.
  assign level     = count;

endmodule

`default_nettype wire

// ==== verilog/csc_top.sv ====
`default_nettype none

module csc_top
  import csc_pixel_pkg::*;
  import csc_coef_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [7:0]  paddr,
  input  wire  [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  wire         in_valid,
  input  wire pixel_t in_pixel,
  output logic        in_ready,
  output logic        out_valid,
  output pixel_t      out_pixel,
  input  wire         out_ready
);

  coef_t      c0_0, c0_1, c0_2, c1_0, c1_1, c1_2, c2_0, c2_1, c2_2;
  term_t      off_0, off_1, off_2;
  comp_t      res_0, res_1, res_2;
  logic       wr_en;
  logic [4:0] level;

  csc_coef_regs u_regs (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .level(level),
    .coef_c0_0(c0_0), .coef_c0_1(c0_1), .coef_c0_2(c0_2),
    .coef_c1_0(c1_0), .coef_c1_1(c1_1), .coef_c1_2(c1_2),
    .coef_c2_0(c2_0), .coef_c2_1(c2_1), .coef_c2_2(c2_2),
    .offset_c0(off_0), .offset_c1(off_1), .offset_c2(off_2)
  );

  // Only channel 0 carries the accept pulse through to the FIFO.
  csc_channel u_ch_0 (.clk(clk), .rst_n(rst_n), .pixel(in_pixel), .coef_0(c0_0),
    .coef_1(c0_1), .coef_2(c0_2), .offset(off_0), .tag_in({in_valid, in_ready}),
    .tag_out(wr_en), .result(res_0));
  csc_channel u_ch_1 (.clk(clk), .rst_n(rst_n), .pixel(in_pixel), .coef_0(c1_0),
    .coef_1(c1_1), .coef_2(c1_2), .offset(off_1), .tag_in({in_valid, in_ready}),
    .tag_out(), .result(res_1));
  csc_channel u_ch_2 (.clk(clk), .rst_n(rst_n), .pixel(in_pixel), .coef_0(c2_0),
    .coef_1(c2_1), .coef_2(c2_2), .offset(off_2), .tag_in({in_valid, in_ready}),
    .tag_out(), .result(res_2));

  csc_pixel_fifo u_fifo (
    .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_pixel({res_2, res_1, res_0}),
    .in_ready(in_ready), .out_valid(out_valid), .out_pixel(out_pixel),
    .out_ready(out_ready), .level(level)
  );

endmodule

`default_nettype wire

// ==== tb/csc_tb.sv ====
`default_nettype none

`include "csc_consts.svh"

module csc_tb
  import csc_pixel_pkg::*;
  import csc_coef_pkg::*;
();

  localparam int MAX_CYCLES = 4000; // The tests need about 1500 cycles with stalls.

  // BT.601 studio-range matrix in register order. Components 0..2 are R, G, B.
  localparam logic [31:0] YCC [12] = '{
    32'h0041d, 32'h00810, 32'h00191, 32'h10000,
    32'h1025e, 32'h104a8, 32'h00706, 32'h80000,
    32'h00706, 32'h105e3, 32'h10123, 32'h80000
  };

  logic        clk = 1'b0;
  logic        rst_n, psel, penable, pwrite, pready, pslverr;
  logic [7:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        in_valid, in_ready, out_valid, out_ready;
  pixel_t      in_pixel, out_pixel;
  coef_t       coef_m [3][3]; // Shadow of the programmed registers.
  term_t       off_m [3];
  pixel_t      exp_q [$];
  logic [31:0] lfsr = 32'hefef_f921;
  string       cur_test = "reset";
  int          errors = 0, checks = 0, test_start = 0, cycles = 0;

  csc_top dut0 (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycles, cur_test);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic pixel_t model_pixel(input pixel_t p);
    pixel_t r;
    longint sum;
    longint mag;
    for (int c = 0; c < 3; c++) begin
      mag = off_m[c][`CSC_TERM_W-2:0];
      sum = off_m[c][`CSC_TERM_W-1] ? -mag : mag;
      for (int t = 0; t < 3; t++) begin
        mag = p[t] * coef_m[c][t][`CSC_MAG_W-1:0];
        sum += coef_m[c][t][`CSC_MAG_W] ? -mag : mag;
      end
      if (sum < 0) r[c] = 8'd0;
      else if (sum >= (longint'(1) << (`CSC_FRAC_W + `CSC_COMP_W))) r[c] = 8'd255;
      else r[c] = comp_t'(sum >> `CSC_FRAC_W);
    end
    return r;
  endfunction

  task automatic report(input string name, input string exp, input string act);
    errors++;
    $display("[FAIL] %s %s: expected %s, actual %s", cur_test, name, exp, act);
  endtask

  task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
    checks++;
    if (exp !== act) report(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_comp(input string name, input comp_t exp, input comp_t act);
    checks++;
    if (exp !== act) report(name, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) report(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) report(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  // Every accepted pixel queues its expected result; every pop is compared in order.
  always @(negedge clk) begin
    if (rst_n) begin
      if (in_valid && in_ready) exp_q.push_back(model_pixel(in_pixel));
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Test %s got output pixel %h when none was expected", cur_test, out_pixel);
        end else begin
          check_pixel("out_pixel", exp_q.pop_front(), out_pixel);
        end
      end
    end
  end

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel = 1'b1;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err = pslverr;
    check_bit("pready", 1'b1, pready);
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_reg(input int idx, input logic [31:0] v);
    logic [31:0] unused;
    logic err;
    apb_access(1'b1, `CSC_ADDR_COEF_BASE + 8'(idx * 4), v, unused, err);
    check_bit("pslverr on register write", 1'b0, err);
    if (idx % 4 == 3) off_m[idx / 4] = v[`CSC_TERM_W-1:0];
    else coef_m[idx / 4][idx % 4] = v[`CSC_MAG_W:0];
  endtask

  task automatic send_pixel(input pixel_t p, input bit rnd_ready);
    logic acc;
    in_valid = 1'b1;
    in_pixel = p;
    do begin
      @(negedge clk);
      acc = in_ready;
      @(posedge clk);
      #1 if (rnd_ready) out_ready = 1'(rand_bits(1));
    end while (!acc);
    in_valid = 1'b0;
  endtask

  task automatic drain(input bit rnd_ready);
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1 if (rnd_ready) out_ready = 1'(rand_bits(1));
    end
    out_ready = 1'b1;
    check_bit("out_valid after drain", 1'b0, out_valid);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_start = errors;
  endtask

  task automatic end_test();
    $display("%-14s %s, %0d errors", cur_test, (errors == test_start) ? "ok" : "bad",
             errors - test_start);
  endtask

  task automatic test_reset_state();
    logic [31:0] d;
    logic err;
    begin_test("reset_state");
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("in_ready", 1'b1, in_ready);
    check_bit("pslverr", 1'b0, pslverr);
    for (int i = 0; i < 12; i++) begin
      apb_access(1'b0, 8'(i * 4), '0, d, err);
      check_word($sformatf("register %0d", i), '0, d);
    end
    apb_access(1'b0, `CSC_ADDR_LEVEL, '0, d, err);
    check_word("level", '0, d);
    end_test();
  endtask

  task automatic test_apb_access();
    logic [31:0] wr [12];
    logic [31:0] d;
    logic err;
    begin_test("apb_access");
    for (int i = 0; i < 12; i++) begin
      wr[i] = rand_bits(32);
      set_reg(i, wr[i]);
    end
    // Reads return only the stored field, zero-extended.
    for (int i = 0; i < 12; i++) begin
      apb_access(1'b0, 8'(i * 4), '0, d, err);
      check_word($sformatf("register %0d", i),
                 wr[i] & ((i % 4 == 3) ? 32'h01ff_ffff : 32'h0001_ffff), d);
    end
    apb_access(1'b1, 8'h40, '0, d, err);
    check_bit("pslverr at 0x40", 1'b1, err);
    apb_access(1'b1, `CSC_ADDR_LEVEL, 32'h5, d, err);
    check_bit("pslverr on level write", 1'b1, err);
    apb_access(1'b0, `CSC_ADDR_LEVEL, '0, d, err);
    check_bit("pslverr on level read", 1'b0, err);
    end_test();
  endtask

  task automatic test_identity();
    begin_test("identity");
    for (int i = 0; i < 12; i++) set_reg(i, (i % 4 == i / 4) ? 32'h1000 : 32'h0);
    repeat (64) send_pixel(24'(rand_bits(24)), 1'b0);
    drain(1'b0);
    end_test();
  endtask

  task automatic test_rgb_to_ycbcr();
    begin_test("rgb_to_ycbcr");
    for (int i = 0; i < 12; i++) set_reg(i, YCC[i]);
    repeat (200) send_pixel(24'(rand_bits(24)), 1'b0);
    drain(1'b0);
    end_test();
  endtask

  task automatic test_clamping();
    begin_test("clamping");
    // Channel 0 gets -1.0 times R, channel 1 gets 2.0 times G, channel 2 an offset of 300.
    for (int i = 0; i < 12; i++) begin
      set_reg(i, (i == 0) ? 32'h11000 : (i == 5) ? 32'h2000 : (i == 11) ? 32'h12c000 : 32'h0);
    end
    out_ready = 1'b0;
    send_pixel({8'd10, 8'd200, 8'd50}, 1'b0);
    while (!out_valid) begin
      @(posedge clk);
      #1;
    end
    check_comp("negative sum", 8'd0, out_pixel[0]);
    check_comp("oversized product", 8'd255, out_pixel[1]);
    check_comp("oversized offset", 8'd255, out_pixel[2]);
    out_ready = 1'b1;
    repeat (16) send_pixel(24'(rand_bits(24)), 1'b0);
    drain(1'b0);
    end_test();
  endtask

  task automatic test_back_pressure();
    logic [31:0] d;
    logic err;
    begin_test("back_pressure");
    for (int i = 0; i < 12; i++) set_reg(i, YCC[i]);
    out_ready = 1'b0;
    while (in_ready) send_pixel(24'(rand_bits(24)), 1'b0);
    // Ready drops once the level passes 9, so the pixels in flight exactly fill the FIFO.
    check_word("pixels taken when stalled", `CSC_FIFO_DEPTH, 32'(exp_q.size()));
    repeat (`CSC_LAT + 1) @(posedge clk);
    #1 apb_access(1'b0, `CSC_ADDR_LEVEL, '0, d, err);
    check_word("level after stall", 32'(exp_q.size()), d);
    repeat (40) send_pixel(24'(rand_bits(24)), 1'b1);
    drain(1'b1);
    end_test();
  endtask

  initial begin
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    in_valid = 1'b0;
    in_pixel = '0;
    out_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    test_reset_state();
    test_apb_access();
    test_identity();
    test_rgb_to_ycbcr();
    test_clamping();
    test_back_pressure();
    $display("Totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("ALL CHECKS PASSED");
    else $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verilog
verilog/csc_pixel_pkg.sv
verilog/csc_coef_pkg.sv
verilog/csc_coef_regs.sv
verilog/csc_mul.sv
verilog/csc_add.sv
verilog/csc_channel.sv
verilog/csc_pixel_fifo.sv
verilog/csc_top.sv
tb/csc_tb.sv
